// ==== include/i4_defs.svh ====
// Widths, counts and fixed mode costs shared by the 4x4 intra mode picker

`ifndef I4_DEFS_SVH
`define I4_DEFS_SVH

// ------------------------------------------------------------------------
// Data widths
// ------------------------------------------------------------------------
`define I4_PIX_W      8
`define I4_SSE_W      20
`define I4_LAMBDA_W   16
`define I4_SCORE_W    32
`define I4_TOTAL_W    36

// ------------------------------------------------------------------------
// Counts
// ------------------------------------------------------------------------
`define I4_NUM_MODES  4
`define I4_NUM_BLK    16

// ------------------------------------------------------------------------
// Fixed mode costs, weighted by lambda
// ------------------------------------------------------------------------
`define I4_COST_DC    40
`define I4_COST_TM    1151
`define I4_COST_VE    1723
`define I4_COST_HE    1874

`endif

// ==== rtl/i4_pkg.sv ====
// Types for the 4x4 intra mode picker: blocks, contexts, payloads, results

`include "i4_defs.svh"

package i4_pkg;

    // Mode number, also the index into a prediction set
    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } i4_mode_t;

    // One 4x4 block, raster pixels or 32-bit rows
    typedef union packed {
        logic [15:0][`I4_PIX_W-1:0]  pix;
        logic [3:0][4*`I4_PIX_W-1:0] row;
    } blk4_u;

    typedef blk4_u [`I4_NUM_MODES-1:0] pred_set_t;

    typedef struct packed {
        logic [`I4_PIX_W-1:0]      top_left;
        logic [3:0][`I4_PIX_W-1:0] top;
        logic [3:0][`I4_PIX_W-1:0] left;
    } nbr_ctx_t;

    typedef struct packed {
        logic [255:0][`I4_PIX_W-1:0] src;
        logic [15:0][`I4_PIX_W-1:0]  top;
        logic [15:0][`I4_PIX_W-1:0]  left;
        logic [`I4_PIX_W-1:0]        top_left;
        logic [`I4_LAMBDA_W-1:0]     lambda;
    } mb_req_t;

    typedef struct packed {
        i4_mode_t                mode;
        logic [`I4_SCORE_W-1:0]  score;
        blk4_u                   blk;
    } eval_res_t;

endpackage

// ==== rtl/i4_predict.sv ====
// 4x4 intra predictors
// Builds the DC, TM, VE and HE blocks from one neighbour context

`timescale 1ns/1ps

module i4_predict
    import i4_pkg::*;
(
    input  nbr_ctx_t  ctx_i,
    output pred_set_t pred_o
);

    logic [10:0] dc_sum;
    logic [7:0]  dc_pix;

    // left + top - top_left, clipped to the pixel range
    function automatic logic [7:0] tm_pix(
        input logic [7:0] l,
        input logic [7:0] t,
        input logic [7:0] tl
    );
        logic signed [9:0] v;
        logic [7:0]        res;
        v = $signed({2'b00, l}) + $signed({2'b00, t}) - $signed({2'b00, tl});
        if (v < 0) begin
            res = 8'd0;
        end else if (v > 10'sd255) begin
            res = 8'd255;
        end else begin
            res = v[7:0];
        end
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // DC: rounded mean of four top and four left pixels
    // ------------------------------------------------------------------------
    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++) begin
            dc_sum = dc_sum + ctx_i.top[i] + ctx_i.left[i];
        end
    end

    assign dc_pix = dc_sum[10:3];

    // ------------------------------------------------------------------------
    // Pixel-wise fill of all four predictions
    // ------------------------------------------------------------------------
    always_comb begin
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                pred_o[MODE_DC].pix[4*y+x] = dc_pix;
                pred_o[MODE_TM].pix[4*y+x] = tm_pix(ctx_i.left[y], ctx_i.top[x],
                                                     ctx_i.top_left);
                // Columns copy top, rows copy left
                pred_o[MODE_VE].pix[4*y+x] = ctx_i.top[x];
                pred_o[MODE_HE].pix[4*y+x] = ctx_i.left[y];
            end
        end
    end

endmodule

// ==== rtl/i4_mode_eval.sv ====
// 4x4 mode evaluator
// Row-serial squared error for every mode, then rate-distortion score and best pick

`timescale 1ns/1ps
`include "i4_defs.svh"

module i4_mode_eval
    import i4_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  blk4_u                   src_i,
    input  pred_set_t               pred_i,
    input  logic [`I4_LAMBDA_W-1:0] lambda_i,
    output eval_res_t               res_o,
    output logic                    valid_o
);

    localparam logic [15:0] MODE_COST [`I4_NUM_MODES] = '{
        16'(`I4_COST_DC), 16'(`I4_COST_TM), 16'(`I4_COST_VE), 16'(`I4_COST_HE)
    };

    blk4_u                    src_q;
    pred_set_t                pred_q;
    logic [1:0]               row_q;
    logic                     acc_q;
    logic                     cmp_q;
    logic [`I4_SSE_W-1:0]     sse_q [`I4_NUM_MODES];
    logic [4*`I4_PIX_W-1:0]   src_row;
    logic [4*`I4_PIX_W-1:0]   pred_row [`I4_NUM_MODES];
    logic [`I4_SCORE_W-1:0]   score [`I4_NUM_MODES];
    logic [`I4_SCORE_W-1:0]   best_score;
    logic [1:0]               best_idx;

    function automatic logic [17:0] row_sse(
        input logic [3:0][7:0] a,
        input logic [3:0][7:0] b
    );
        logic [17:0] acc;
        logic [7:0]  d;
        acc = '0;
        for (int i = 0; i < 4; i++) begin
            d   = (a[i] > b[i]) ? a[i] - b[i] : b[i] - a[i];
            acc = acc + d * d;
        end
        return acc;
    endfunction

    // Row 0 comes straight from the inputs in the start cycle
    always_comb begin
        src_row = start_i ? src_i.row[0] : src_q.row[row_q];
        for (int m = 0; m < `I4_NUM_MODES; m++) begin
            pred_row[m] = start_i ? pred_i[m].row[0] : pred_q[m].row[row_q];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q   <= 1'b0;
            cmp_q   <= 1'b0;
            row_q   <= 2'd0;
            valid_o <= 1'b0;
        end else begin
            cmp_q   <= acc_q && (row_q == 2'd3);
            valid_o <= cmp_q;
            if (start_i) begin
                acc_q <= 1'b1;
                row_q <= 2'd1;
            end else if (acc_q) begin
                row_q <= row_q + 2'd1;
                if (row_q == 2'd3) begin
                    acc_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            src_q  <= src_i;
            pred_q <= pred_i;
        end
        if (start_i || acc_q) begin
            for (int m = 0; m < `I4_NUM_MODES; m++) begin
                sse_q[m] <= (start_i ? '0 : sse_q[m]) +
                            `I4_SSE_W'(row_sse(src_row, pred_row[m]));
            end
        end
        if (cmp_q) begin
            res_o.mode  <= i4_mode_t'(best_idx);
            res_o.score <= best_score;
            res_o.blk   <= pred_q[best_idx];
        end
    end

    // ------------------------------------------------------------------------
    // Score = 256 * SSE + lambda * mode cost; ties keep the lower mode
    // ------------------------------------------------------------------------
    always_comb begin
        for (int m = 0; m < `I4_NUM_MODES; m++) begin
            score[m] = (`I4_SCORE_W'(sse_q[m]) << 8) +
                       `I4_SCORE_W'(lambda_i) * `I4_SCORE_W'(MODE_COST[m]);
        end
    end

    always_comb begin
        best_idx   = 2'd0;
        best_score = score[0];
        for (int m = 1; m < `I4_NUM_MODES; m++) begin
            if (score[m] < best_score) begin
                best_idx   = 2'(m);
                best_score = score[m];
            end
        end
    end

endmodule

// ==== rtl/i4_neighbors.sv ====
// Neighbour buffer for the 4x4 picker
// Keeps the chosen blocks and registers the edge context of the next block

`timescale 1ns/1ps
`include "i4_defs.svh"

module i4_neighbors
    import i4_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 fetch_i,
    input  logic [3:0]                           blk_idx_i,
    input  mb_req_t                              edge_i,
    input  logic                                 store_i,
    input  blk4_u                                blk_i,
    output nbr_ctx_t                             ctx_o,
    output logic [`I4_NUM_BLK*16*`I4_PIX_W-1:0] mb_o
);

    blk4_u      buf_q [`I4_NUM_BLK];
    logic [1:0] blk_r;
    logic [1:0] blk_c;
    logic [3:0] idx_up;
    logic [3:0] idx_lf;
    logic [3:0] idx_ul;
    logic [3:0] top_pos;
    logic [3:0] left_pos;
    nbr_ctx_t   ctx_d;

    assign blk_r    = blk_idx_i[3:2];
    assign blk_c    = blk_idx_i[1:0];
    assign idx_up   = blk_idx_i - 4'd4;
    assign idx_lf   = blk_idx_i - 4'd1;
    assign idx_ul   = blk_idx_i - 4'd5;
    assign top_pos  = {blk_c, 2'b00} - 4'd1;
    assign left_pos = {blk_r, 2'b00} - 4'd1;

    // ------------------------------------------------------------------------
    // Context select: macroblock edge or a block already chosen
    // ------------------------------------------------------------------------
    always_comb begin
        if (blk_r == 2'd0) begin
            ctx_d.top = edge_i.top[{blk_c, 2'b00} +: 4];
        end else begin
            ctx_d.top = buf_q[idx_up].row[3];
        end

        if (blk_c == 2'd0) begin
            ctx_d.left = edge_i.left[{blk_r, 2'b00} +: 4];
        end else begin
            // Right column of the block to the left, top pixel lowest
            ctx_d.left = {buf_q[idx_lf].pix[15], buf_q[idx_lf].pix[11],
                          buf_q[idx_lf].pix[7], buf_q[idx_lf].pix[3]};
        end

        case ({blk_r == 2'd0, blk_c == 2'd0})
            2'b11:   ctx_d.top_left = edge_i.top_left;
            2'b10:   ctx_d.top_left = edge_i.top[top_pos];
            2'b01:   ctx_d.top_left = edge_i.left[left_pos];
            default: ctx_d.top_left = buf_q[idx_ul].pix[15];
        endcase
    end

    always_ff @(posedge clk) begin
        if (fetch_i) begin
            ctx_o <= ctx_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < `I4_NUM_BLK; b++) begin
                buf_q[b] <= '0;
            end
        end else if (store_i) begin
            buf_q[blk_idx_i] <= blk_i;
        end
    end

    // Blocks back to macroblock raster order
    always_comb begin
        mb_o = '0;
        for (int b = 0; b < `I4_NUM_BLK; b++) begin
            for (int y = 0; y < 4; y++) begin
                mb_o[((4*(b/4)+y)*16 + 4*(b%4))*`I4_PIX_W +: 4*`I4_PIX_W] = buf_q[b].row[y];
            end
        end
    end

endmodule

// ==== rtl/i4_ctrl.sv ====
// Control for the 4x4 picker
// Request handshake, block sequencing, source block extraction, mode and score collection

`timescale 1ns/1ps
`include "i4_defs.svh"

module i4_ctrl
    import i4_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_i,
    input  mb_req_t                   req_data_i,
    input  eval_res_t                 res_i,
    input  logic                      res_valid_i,
    output logic                      ack_o,
    output logic                      fetch_o,
    output logic                      eval_start_o,
    output logic [3:0]                blk_idx_o,
    output blk4_u                     src_blk_o,
    output logic                      store_o,
    output blk4_u                     store_blk_o,
    output logic [2*`I4_NUM_BLK-1:0]  modes_o,
    output logic [`I4_TOTAL_W-1:0]    score_o
);

    // One-hot states
    localparam logic [5:0] ST_IDLE    = 6'b000001;
    localparam logic [5:0] ST_FETCH   = 6'b000010;
    localparam logic [5:0] ST_EVAL    = 6'b000100;
    localparam logic [5:0] ST_STORE   = 6'b001000;
    localparam logic [5:0] ST_DONE    = 6'b010000;
    localparam logic [5:0] ST_RELEASE = 6'b100000;

    logic [5:0] state_q;
    logic [5:0] state_d;
    logic [2:0] eval_cnt_q;
    logic [3:0] blk_idx_q;
    logic       last_blk;
    logic [7:0] src_base;

    assign last_blk    = (blk_idx_q == 4'(`I4_NUM_BLK - 1));
    assign fetch_o     = (state_q == ST_FETCH);
    assign store_o     = (state_q == ST_STORE) && res_valid_i;
    assign store_blk_o = res_i.blk;
    assign blk_idx_o   = blk_idx_q;

    // Top-left pixel of block (r, c) is raster pixel 64r + 4c
    assign src_base = {blk_idx_q[3:2], 2'b00, blk_idx_q[1:0], 2'b00};

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    state_d = ST_FETCH;
                end
            end
            ST_FETCH: state_d = ST_EVAL;
            ST_EVAL: begin
                // Four row cycles and the compare cycle
                if (eval_cnt_q == 3'd4) begin
                    state_d = ST_STORE;
                end
            end
            ST_STORE: begin
                if (res_valid_i) begin
                    state_d = last_blk ? ST_DONE : ST_FETCH;
                end
            end
            ST_DONE: state_d = ST_RELEASE;
            ST_RELEASE: begin
                if (!req_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            eval_cnt_q   <= 3'd0;
            blk_idx_q    <= 4'd0;
            eval_start_o <= 1'b0;
            ack_o        <= 1'b0;
            modes_o      <= '0;
            score_o      <= '0;
        end else begin
            state_q      <= state_d;
            eval_start_o <= fetch_o;
            eval_cnt_q   <= (state_q == ST_EVAL) ? eval_cnt_q + 3'd1 : 3'd0;

            if ((state_q == ST_IDLE) && req_i) begin
                blk_idx_q <= 4'd0;
                score_o   <= '0;
            end

            if (store_o) begin
                modes_o[2*blk_idx_q +: 2] <= res_i.mode;
                score_o   <= score_o + `I4_TOTAL_W'(res_i.score);
                blk_idx_q <= blk_idx_q + 4'd1;
            end

            if (state_q == ST_DONE) begin
                ack_o <= 1'b1;
            end else if ((state_q == ST_RELEASE) && !req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    // Source block rows, ready with the evaluation start
    always_ff @(posedge clk) begin
        if (fetch_o) begin
            for (int y = 0; y < 4; y++) begin
                src_blk_o.row[y] <= req_data_i.src[src_base + 8'(16 * y) +: 4];
            end
        end
    end

endmodule

// ==== rtl/pick_best_intra4.sv ====
// Best 4x4 intra luma mode picker for one 16x16 macroblock
// Top level with a four-phase req/ack request port

`timescale 1ns/1ps
`include "i4_defs.svh"

module pick_best_intra4
    import i4_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_i,
    input  mb_req_t                              req_data_i,
    output logic                                 ack_o,
    output logic [`I4_NUM_BLK*16*`I4_PIX_W-1:0] yout_o,
    output logic [2*`I4_NUM_BLK-1:0]             modes_o,
    output logic [`I4_TOTAL_W-1:0]               score_o
);

    logic      fetch;
    logic      eval_start;
    logic      store;
    logic      res_valid;
    logic [3:0] blk_idx;
    nbr_ctx_t  ctx;
    pred_set_t pred;
    blk4_u     src_blk;
    blk4_u     store_blk;
    eval_res_t res;

    i4_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .res_i        (res),
        .res_valid_i  (res_valid),
        .ack_o        (ack_o),
        .fetch_o      (fetch),
        .eval_start_o (eval_start),
        .blk_idx_o    (blk_idx),
        .src_blk_o    (src_blk),
        .store_o      (store),
        .store_blk_o  (store_blk),
        .modes_o      (modes_o),
        .score_o      (score_o)
    );

    i4_neighbors u_neighbors (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_i   (fetch),
        .blk_idx_i (blk_idx),
        .edge_i    (req_data_i),
        .store_i   (store),
        .blk_i     (store_blk),
        .ctx_o     (ctx),
        .mb_o      (yout_o)
    );

    i4_predict u_predict (
        .ctx_i  (ctx),
        .pred_o (pred)
    );

    i4_mode_eval u_eval (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (eval_start),
        .src_i    (src_blk),
        .pred_i   (pred),
        .lambda_i (req_data_i.lambda),
        .res_o    (res),
        .valid_o  (res_valid)
    );

endmodule

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset generator

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== verif/tb_pick_best_intra4.sv ====
// Testbench for the 4x4 intra mode picker
// Directed and random macroblocks checked against a reference model

`timescale 1ns/1ps
`include "i4_defs.svh"

module tb_pick_best_intra4
    import i4_pkg::*;
();

    localparam int N_REQ        = 12;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = N_REQ * 130 + RESET_CYCLES;

    logic          clk;
    logic          rst_n;
    logic          req;
    mb_req_t       req_data;
    logic          ack;
    logic [2047:0] yout;
    logic [31:0]   modes;
    logic [35:0]   score;

    logic [2047:0] exp_mb;
    logic [31:0]   exp_modes;
    logic [35:0]   exp_score;
    logic [31:0]   lfsr_q    = 32'hb638517e;
    logic          ack_prev  = 1'b0;
    int            cycle_cnt = 0;

    tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pick_best_intra4 u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req),
        .req_data_i (req_data),
        .ack_o      (ack),
        .yout_o     (yout),
        .modes_o    (modes),
        .score_o    (score)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [2047:0] got,
                               input logic [2047:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int mode_cost(input int m);
        case (m)
            0:       return `I4_COST_DC;
            1:       return `I4_COST_TM;
            2:       return `I4_COST_VE;
            default: return `I4_COST_HE;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Reference model walking the blocks in raster order
    // ------------------------------------------------------------------------
    function automatic void ref_model(input mb_req_t r, output logic [2047:0] mb,
                                      output logic [31:0] mode_word,
                                      output logic [35:0] total);
        int     out_pix [16][16];
        int     top [4];
        int     left [4];
        int     pr [4][16];
        int     br;
        int     bc;
        int     tl;
        int     dc;
        int     t;
        int     d;
        int     best;
        longint sse;
        longint sc;
        longint best_sc;
        mode_word = '0;
        total     = '0;
        for (int b = 0; b < 16; b++) begin
            br = b / 4;
            bc = b % 4;
            for (int i = 0; i < 4; i++) begin
                top[i]  = (br == 0) ? r.top[4*bc+i] : out_pix[4*br-1][4*bc+i];
                left[i] = (bc == 0) ? r.left[4*br+i] : out_pix[4*br+i][4*bc-1];
            end
            if (br == 0 && bc == 0) tl = r.top_left;
            else if (br == 0) tl = r.top[4*bc-1];
            else if (bc == 0) tl = r.left[4*br-1];
            else tl = out_pix[4*br-1][4*bc-1];
            dc = (top[0] + top[1] + top[2] + top[3] + left[0] + left[1] + left[2]
                  + left[3] + 4) / 8;
            for (int p = 0; p < 16; p++) begin
                t        = left[p/4] + top[p%4] - tl;
                pr[0][p] = dc;
                pr[1][p] = (t < 0) ? 0 : ((t > 255) ? 255 : t);
                pr[2][p] = top[p%4];
                pr[3][p] = left[p/4];
            end
            best    = 0;
            best_sc = 0;
            for (int m = 0; m < 4; m++) begin
                sse = 0;
                for (int p = 0; p < 16; p++) begin
                    d   = int'(r.src[(4*br + p/4)*16 + 4*bc + p%4]) - pr[m][p];
                    sse = sse + d * d;
                end
                sc = 256 * sse + longint'(r.lambda) * mode_cost(m);
                // Strict compare keeps the lower mode on a tie
                if (m == 0 || sc < best_sc) begin
                    best    = m;
                    best_sc = sc;
                end
            end
            mode_word[2*b +: 2] = best[1:0];
            total               = total + 36'(best_sc);
            for (int p = 0; p < 16; p++) begin
                out_pix[4*br + p/4][4*bc + p%4] = pr[best][p];
            end
        end
        for (int y = 0; y < 16; y++) begin
            for (int x = 0; x < 16; x++) begin
                mb[8*(16*y+x) +: 8] = 8'(out_pix[y][x]);
            end
        end
    endfunction

    task automatic make_random(input logic zero_lambda, output mb_req_t r);
        for (int i = 0; i < 256; i++) r.src[i] = 8'(rand_bits(8));
        for (int i = 0; i < 16; i++) begin
            r.top[i]  = 8'(rand_bits(8));
            r.left[i] = 8'(rand_bits(8));
        end
        r.top_left = 8'(rand_bits(8));
        r.lambda   = zero_lambda ? '0 : 16'(rand_bits(16));
    endtask

    // Full four-phase request with outputs captured at the first ack
    task automatic run_request(input mb_req_t r, output logic [2047:0] got_mb,
                               output logic [31:0] got_modes, output logic [35:0] got_score);
        ref_model(r, exp_mb, exp_modes, exp_score);
        @(posedge clk);
        req_data <= r;
        req      <= 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);
        got_mb    = yout;
        got_modes = modes;
        got_score = score;
        repeat (3) @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Compare process and cycle limit
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (ack && !ack_prev && !req) abort_run("ack_o rose with no open request");
            if (!ack && ack_prev && req) abort_run("ack_o fell while req_i was still high");
            if (ack) begin
                check_value("yout_o", yout, exp_mb);
                check_value("modes_o", modes, exp_modes);
                check_value("score_o", score, exp_score);
            end
        end
        ack_prev <= ack;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) abort_run("Timeout: the requests did not finish in time");
    end

    initial begin
        mb_req_t       r;
        logic [2047:0] got_mb;
        logic [31:0]   got_modes;
        logic [35:0]   got_score;
        logic [7:0]    v;
        req      = 1'b0;
        req_data = '0;
        wait (rst_n === 1'b1);
        repeat (2) @(posedge clk);
        check_value("ack_o", ack, '0);

        // Flat block with zero error in every mode and DC cheapest
        v = 8'(rand_bits(8));
        r.src      = {256{v}};
        r.top      = {16{v}};
        r.left     = {16{v}};
        r.top_left = v;
        r.lambda   = 16'(rand_bits(16));
        run_request(r, got_mb, got_modes, got_score);
        check_value("modes_o", got_modes, '0);
        check_value("score_o", got_score, 64'(r.lambda) * 16 * `I4_COST_DC);
        check_value("yout_o", got_mb, {256{v}});

        // Vertical stripes with a far left edge and a zero corner
        for (int i = 0; i < 16; i++) begin
            r.top[i]  = 8'(40 * (i % 4) + 2 * i);
            r.left[i] = 8'd255;
        end
        for (int i = 0; i < 256; i++) r.src[i] = r.top[i % 16];
        r.top_left = 8'd0;
        r.lambda   = 16'd1;
        run_request(r, got_mb, got_modes, got_score);
        // Block 0 needs VE and later blocks rebuild the columns more cheaply with TM
        check_value("modes_o", got_modes, 32'h5555_5556);
        check_value("score_o", got_score, `I4_COST_VE + 15 * `I4_COST_TM);
        check_value("yout_o", got_mb, r.src);

        // Zero lambda and constant edges make all modes tie so DC wins everywhere
        make_random(1'b1, r);
        v          = 8'(rand_bits(8));
        r.top      = {16{v}};
        r.left     = {16{v}};
        r.top_left = v;
        run_request(r, got_mb, got_modes, got_score);
        check_value("modes_o", got_modes, '0);
        check_value("yout_o", got_mb, {256{v}});

        make_random(1'b1, r);
        run_request(r, got_mb, got_modes, got_score);

        // Random macroblocks back to back
        for (int n = 0; n < 8; n++) begin
            make_random(1'b0, r);
            run_request(r, got_mb, got_modes, got_score);
        end

        repeat (2) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
rtl/i4_pkg.sv
rtl/i4_predict.sv
rtl/i4_mode_eval.sv
rtl/i4_neighbors.sv
rtl/i4_ctrl.sv
rtl/pick_best_intra4.sv
verif/tb_clk_gen.sv
verif/tb_pick_best_intra4.sv
